// File: common/socket_defines.svh
/*
  build parameters of the compute socket
  SOCKET_TAG_W must be wide enough to hold a core index
  the DCR data word is SOCKET_DATA_W bits wide
*/
`ifndef SOCKET_DEFINES_SVH
`define SOCKET_DEFINES_SVH

// socket size
`define SOCKET_NUM_CORES   4
`define SOCKET_TAG_W       2

// datapath widths
`define SOCKET_ADDR_W      16
`define SOCKET_DATA_W      32
`define SOCKET_CNT_W       8

// device configuration registers
`define SOCKET_DCR_ADDR_W  2
`define DCR_LAUNCH         0
`define DCR_START          1

`endif

// File: common/socket_pkg.sv
/*
  shared types of the compute socket
  memory requests are read only, tagged with the issuing core index
  the DCR data word has two views, selected by the DCR address
*/
`include "socket_defines.svh"

package socket_pkg;

    ////////////////////////////////////////////////////////////
    // memory port
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`SOCKET_ADDR_W-1:0] addr;
        logic [`SOCKET_TAG_W-1:0]  tag;
    } mem_req_t;

    typedef struct packed {
        logic [`SOCKET_DATA_W-1:0] data;
        logic [`SOCKET_TAG_W-1:0]  tag;
    } mem_rsp_t;

    ////////////////////////////////////////////////////////////
    // DCR write word
    ////////////////////////////////////////////////////////////

    // launch window view
    typedef struct packed {
        logic [`SOCKET_DATA_W-`SOCKET_ADDR_W-`SOCKET_CNT_W-1:0] unused;
        logic [`SOCKET_CNT_W-1:0]                               count;
        logic [`SOCKET_ADDR_W-1:0]                              base;
    } dcr_launch_t;

    // start command view
    typedef struct packed {
        logic [`SOCKET_DATA_W-`SOCKET_NUM_CORES-1:0] unused;
        logic [`SOCKET_NUM_CORES-1:0]                core_mask;
    } dcr_start_t;

    typedef union packed {
        dcr_launch_t launch;
        dcr_start_t  start;
    } dcr_data_u;

    typedef struct packed {
        logic [`SOCKET_DCR_ADDR_W-1:0] addr;
        dcr_data_u                     data;
    } dcr_req_t;

    // window as seen by every core
    typedef struct packed {
        logic [`SOCKET_ADDR_W-1:0] base;
        logic [`SOCKET_CNT_W-1:0]  count;
    } launch_cfg_t;

endpackage

// File: src/dcr_buffer.sv
/*
  DCR write buffer of the socket
  a launch write replaces the stored window on the next edge
  a start write gives a one-cycle start pulse to each masked core
  writes to other DCR addresses are dropped
*/
`timescale 1ns/10ps
`include "socket_defines.svh"

module dcr_buffer import socket_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         dcr_valid,
    input  dcr_req_t                     dcr_req,
    output launch_cfg_t                  cfg,
    output logic [`SOCKET_NUM_CORES-1:0] start
);
    localparam int DCR_ADDR_W = `SOCKET_DCR_ADDR_W;

    dcr_data_u wdata;
    logic      wr_launch;
    logic      wr_start;

    // address decode selects the union view
    assign wdata     = dcr_req.data;
    assign wr_launch = dcr_valid && (dcr_req.addr == DCR_ADDR_W'(`DCR_LAUNCH));
    assign wr_start  = dcr_valid && (dcr_req.addr == DCR_ADDR_W'(`DCR_START));

    ////////////////////////////////////////////////////////////
    // launch window
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (wr_launch) begin
            cfg.base  <= wdata.launch.base;
            cfg.count <= wdata.launch.count;
        end
    end

    ////////////////////////////////////////////////////////////
    // start pulses
    ////////////////////////////////////////////////////////////

    // held for exactly one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start <= '0;
        end else if (wr_start) begin
            start <= wdata.start.core_mask;
        end else begin
            start <= '0;
        end
    end

endmodule

// File: core/compute_core.sv
/*
  one compute core of the socket
  reads count words from base + CORE_ID * count and sums them
  the slice address wraps at the top of the address space
  a start pulse while busy is ignored
  the sum wraps at SOCKET_DATA_W bits
*/
`timescale 1ns/10ps
`include "socket_defines.svh"

module compute_core import socket_pkg::*; #(
    parameter int CORE_ID = 0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  launch_cfg_t               cfg,
    input  logic                      start,
    input  logic                      req_ready,
    input  logic                      rsp_valid,
    input  logic [`SOCKET_DATA_W-1:0] rsp_data,
    output logic                      req_valid,
    output logic [`SOCKET_ADDR_W-1:0] req_addr,
    output logic                      busy,
    output logic [`SOCKET_DATA_W-1:0] result
);
    localparam int ADDR_W = `SOCKET_ADDR_W;
    localparam int CNT_W  = `SOCKET_CNT_W;

    logic [CNT_W-1:0]          count_q;
    logic [CNT_W-1:0]          issued_q;
    logic [CNT_W-1:0]          received_q;
    logic [`SOCKET_DATA_W-1:0] sum_q;
    logic [ADDR_W-1:0]         slice_origin;
    logic                      launch;
    logic                      issue;
    logic                      accept;
    logic                      done;

    // first word of this core's slice
    assign slice_origin = cfg.base + ADDR_W'(CORE_ID) * ADDR_W'(cfg.count);

    assign launch    = start && !busy;
    assign req_valid = busy && (issued_q != count_q);
    assign issue     = req_valid && req_ready;
    assign accept    = busy && rsp_valid;
    // all responses are in, so no more data can arrive
    assign done      = busy && (received_q == count_q);

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            issued_q   <= '0;
            received_q <= '0;
            result     <= '0;
        end else if (launch) begin
            busy       <= 1'b1;
            issued_q   <= '0;
            received_q <= '0;
        end else begin
            if (issue) begin
                issued_q <= issued_q + CNT_W'(1);
            end
            if (accept) begin
                received_q <= received_q + CNT_W'(1);
            end
            if (done) begin
                busy   <= 1'b0;
                result <= sum_q;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // address walk and accumulator
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (launch) begin
            count_q  <= cfg.count;
            req_addr <= slice_origin;
            sum_q    <= '0;
        end else begin
            if (issue) begin
                req_addr <= req_addr + ADDR_W'(1);
            end
            // responses may come back in any order
            if (accept) begin
                sum_q <= sum_q + rsp_data;
            end
        end
    end

endmodule

// File: mem_arb/mem_arb.sv
/*
  round-robin read arbiter in front of the external memory port
  one-entry output register, so one cycle from core request to mem_req_valid
  the tag of each request is the index of the issuing core
  responses are never refused and come back one cycle later as strobes
*/
`timescale 1ns/10ps
`include "socket_defines.svh"

module mem_arb import socket_pkg::*; (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic [`SOCKET_NUM_CORES-1:0]                      req_valid,
    input  logic [`SOCKET_NUM_CORES-1:0][`SOCKET_ADDR_W-1:0]  req_addr,
    input  logic                                              mem_req_ready,
    input  logic                                              mem_rsp_valid,
    input  mem_rsp_t                                          mem_rsp,
    output logic [`SOCKET_NUM_CORES-1:0]                      req_ready,
    output logic                                              mem_req_valid,
    output mem_req_t                                          mem_req,
    output logic [`SOCKET_NUM_CORES-1:0]                      rsp_valid,
    output logic [`SOCKET_DATA_W-1:0]                         rsp_data
);
    localparam int N     = `SOCKET_NUM_CORES;
    localparam int TAG_W = `SOCKET_TAG_W;

    logic [TAG_W-1:0] last_grant;
    logic [TAG_W-1:0] grant_idx;
    logic             grant_any;
    logic             load;

    ////////////////////////////////////////////////////////////
    // round-robin pick
    ////////////////////////////////////////////////////////////

    // scan from the far end so the nearest requester after last_grant wins
    always_comb begin
        int unsigned cand;
        grant_any = 1'b0;
        grant_idx = last_grant;
        for (int i = N; i >= 1; i--) begin
            cand = (int'(last_grant) + i) % N;
            if (req_valid[cand]) begin
                grant_any = 1'b1;
                grant_idx = TAG_W'(cand);
            end
        end
    end

    // register empty or draining this cycle
    assign load      = grant_any && (!mem_req_valid || mem_req_ready);
    assign req_ready = load ? (N'(1) << grant_idx) : '0;

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_req_valid <= 1'b0;
            last_grant    <= TAG_W'(N - 1);
        end else if (load) begin
            mem_req_valid <= 1'b1;
            last_grant    <= grant_idx;
        end else if (mem_req_ready) begin
            mem_req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            mem_req.addr <= req_addr[grant_idx];
            mem_req.tag  <= grant_idx;
        end
    end

    ////////////////////////////////////////////////////////////
    // response routing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= '0;
        end else begin
            rsp_valid <= mem_rsp_valid ? (N'(1) << mem_rsp.tag) : '0;
        end
    end

    // shared by all cores, qualified by rsp_valid
    always_ff @(posedge clk) begin
        if (mem_rsp_valid) begin
            rsp_data <= mem_rsp.data;
        end
    end

endmodule

// File: src/gpu_socket.sv
/*
  compute socket top level
  SOCKET_NUM_CORES cores share one DCR buffer and one memory port
  busy falls when every started core has published its result
*/
`timescale 1ns/10ps
`include "socket_defines.svh"

module gpu_socket import socket_pkg::*; (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              dcr_valid,
    input  dcr_req_t                                          dcr_req,
    input  logic                                              mem_req_ready,
    input  logic                                              mem_rsp_valid,
    input  mem_rsp_t                                          mem_rsp,
    output logic                                              mem_req_valid,
    output mem_req_t                                          mem_req,
    output logic [`SOCKET_NUM_CORES-1:0][`SOCKET_DATA_W-1:0]  result,
    output logic                                              busy
);
    launch_cfg_t                                      cfg;
    logic [`SOCKET_NUM_CORES-1:0]                     start;
    logic [`SOCKET_NUM_CORES-1:0]                     core_req_valid;
    logic [`SOCKET_NUM_CORES-1:0]                     core_req_ready;
    logic [`SOCKET_NUM_CORES-1:0][`SOCKET_ADDR_W-1:0] core_req_addr;
    logic [`SOCKET_NUM_CORES-1:0]                     core_rsp_valid;
    logic [`SOCKET_NUM_CORES-1:0]                     core_busy;
    logic [`SOCKET_DATA_W-1:0]                        rsp_data;

    dcr_buffer i_dcr_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .dcr_valid (dcr_valid),
        .dcr_req   (dcr_req),
        .cfg       (cfg),
        .start     (start)
    );

    ////////////////////////////////////////////////////////////
    // cores
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `SOCKET_NUM_CORES; i++) begin : g_core
        compute_core #(
            .CORE_ID (i)
        ) i_compute_core (
            .clk       (clk),
            .rst_n     (rst_n),
            .cfg       (cfg),
            .start     (start[i]),
            .req_ready (core_req_ready[i]),
            .rsp_valid (core_rsp_valid[i]),
            .rsp_data  (rsp_data),
            .req_valid (core_req_valid[i]),
            .req_addr  (core_req_addr[i]),
            .busy      (core_busy[i]),
            .result    (result[i])
        );
    end

    mem_arb i_mem_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (core_req_valid),
        .req_addr      (core_req_addr),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .req_ready     (core_req_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .rsp_valid     (core_rsp_valid),
        .rsp_data      (rsp_data)
    );

    assign busy = |core_busy;

endmodule

// File: verification/tb_gpu_socket.sv
/*
  testbench of the compute socket
  memory model answers out of order, with random ready and response gaps
  reference model rebuilds every slice sum from the memory word rule
  SEED can be overridden as a top-level parameter
*/
`timescale 1ns/10ps
`include "socket_defines.svh"

module tb_gpu_socket import socket_pkg::*; #(
    parameter int SEED = 33271
);
    localparam int NUM_CORES  = `SOCKET_NUM_CORES;
    localparam int MAX_CYCLES = 20000;

    logic                                             clk;
    logic                                             rst_n;
    logic                                             dcr_valid;
    dcr_req_t                                         dcr_req;
    logic                                             mem_req_ready;
    logic                                             mem_rsp_valid;
    mem_rsp_t                                         mem_rsp;
    logic                                             mem_req_valid;
    mem_req_t                                         mem_req;
    logic [`SOCKET_NUM_CORES-1:0][`SOCKET_DATA_W-1:0] result;
    logic                                             busy;

    logic [`SOCKET_DATA_W-1:0] exp_result [NUM_CORES];
    mem_req_t                  pending [$];
    int                        accepted;
    int                        cycles;

    gpu_socket i_gpu_socket (
        .clk           (clk),
        .rst_n         (rst_n),
        .dcr_valid     (dcr_valid),
        .dcr_req       (dcr_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .result        (result),
        .busy          (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog, well above the longest job sequence
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("** FAIL **");
        $fatal(1, "run stopped by the cycle limit");
    end

    ////////////////////////////////////////////////////////////
    // reference rules
    ////////////////////////////////////////////////////////////

    // memory content is a function of the address
    function automatic logic [31:0] word_at(input logic [15:0] addr);
        return 32'(addr) * 32'd3 + 32'd7;
    endfunction

    function automatic logic [31:0] expected_sum(input logic [15:0] base,
                                                 input logic [7:0] count, input int core);
        logic [15:0] addr;
        logic [31:0] sum;
        sum  = '0;
        addr = base + 16'(core) * 16'(count);
        for (int k = 0; k < int'(count); k++) begin
            sum  = sum + word_at(addr);
            addr = addr + 16'd1;
        end
        return sum;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %0h actual %0h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "check failed");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // memory model
    ////////////////////////////////////////////////////////////

    // handshake sampled at the falling edge, inputs driven after the rising edge
    initial begin : memory_model
        int       idx;
        mem_req_t entry;
        forever begin
            @(negedge clk);
            if (mem_req_valid && mem_req_ready) begin
                pending.push_back(mem_req);
                accepted++;
            end
            @(posedge clk);
            #1;
            mem_req_ready = ($urandom_range(0, 99) < 70);
            mem_rsp_valid = 1'b0;
            if (pending.size() > 0 && $urandom_range(0, 99) < 50) begin
                idx = int'($urandom_range(0, pending.size() - 1));
                entry = pending[idx];
                pending.delete(idx);
                mem_rsp.tag   = entry.tag;
                mem_rsp.data  = word_at(entry.addr);
                mem_rsp_valid = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // host side
    ////////////////////////////////////////////////////////////

    task automatic dcr_write(input logic [1:0] addr, input dcr_data_u data);
        @(posedge clk);
        #1;
        dcr_valid    = 1'b1;
        dcr_req.addr = addr;
        dcr_req.data = data;
        @(posedge clk);
        #1;
        dcr_valid = 1'b0;
    endtask

    task automatic set_window(input logic [15:0] base, input logic [7:0] count);
        dcr_data_u w;
        w = '0;
        w.launch.base  = base;
        w.launch.count = count;
        dcr_write(2'(`DCR_LAUNCH), w);
    endtask

    task automatic start_cores(input logic [3:0] mask);
        dcr_data_u w;
        w = '0;
        w.start.core_mask = mask;
        dcr_write(2'(`DCR_START), w);
    endtask

    task automatic wait_busy_rise();
        do @(negedge clk); while (!busy);
    endtask

    task automatic wait_busy_fall();
        do @(negedge clk); while (busy);
    endtask

    task automatic check_results(input string name);
        for (int i = 0; i < NUM_CORES; i++) begin
            check_value($sformatf("%s core %0d", name, i), exp_result[i], result[i]);
        end
    endtask

    // cores outside the mask keep their old expected result
    task automatic run_job(input string name, input logic [15:0] base,
                           input logic [7:0] count, input logic [3:0] mask);
        set_window(base, count);
        start_cores(mask);
        wait_busy_rise();
        wait_busy_fall();
        for (int i = 0; i < NUM_CORES; i++) begin
            if (mask[i]) begin
                exp_result[i] = expected_sum(base, count, i);
            end
        end
        check_results(name);
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin : main
        logic [15:0] base;
        logic [7:0]  count;
        void'($urandom(SEED));
        rst_n         = 1'b0;
        dcr_valid     = 1'b0;
        dcr_req       = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        accepted      = 0;
        for (int i = 0; i < NUM_CORES; i++) begin
            exp_result[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle state after reset
        @(negedge clk);
        check_value("reset busy", 32'd0, 32'(busy));
        check_value("reset mem_req_valid", 32'd0, 32'(mem_req_valid));
        check_results("reset");

        run_job("single core", 16'($urandom), 8'($urandom_range(1, 20)),
                4'(1 << $urandom_range(0, NUM_CORES - 1)));

        // all cores, request count through the shared port
        base     = 16'($urandom);
        count    = 8'($urandom_range(1, 20));
        accepted = 0;
        run_job("all cores", base, count, 4'hF);
        check_value("request count", 32'(NUM_CORES) * 32'(count), 32'(accepted));

        run_job("partial mask", 16'($urandom), 8'($urandom_range(1, 20)),
                4'($urandom_range(1, 14)));

        // second window and start land while every core is still busy
        base  = 16'($urandom);
        count = 8'd20;
        set_window(base, count);
        start_cores(4'hF);
        wait_busy_rise();
        set_window(base + 16'd100, 8'd5);
        start_cores(4'hF);
        wait_busy_fall();
        for (int i = 0; i < NUM_CORES; i++) begin
            exp_result[i] = expected_sum(base, count, i);
        end
        check_results("start while busy");
        run_job("count zero", 16'($urandom), 8'd0, 4'hF);

        for (int j = 0; j < 20; j++) begin
            run_job($sformatf("random job %0d", j), 16'($urandom),
                    8'($urandom_range(0, 20)), 4'($urandom_range(1, 15)));
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// File: src.f
+incdir+common
common/socket_pkg.sv
src/dcr_buffer.sv
core/compute_core.sv
mem_arb/mem_arb.sv
src/gpu_socket.sv
verification/tb_gpu_socket.sv

// File: Makefile
# Verilator build and run of the compute socket testbench

VERILATOR ?= verilator
TOP       ?= tb_gpu_socket
SEED      ?= 33271
TRACE     ?= 0
BUILD_DIR ?= obj_dir

ifeq ($(TRACE),1)
TRACE_FLAGS = --trace
else
TRACE_FLAGS =
endif

VFLAGS = --binary -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR) -GSEED=$(SEED) $(TRACE_FLAGS)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: TOP SEED TRACE BUILD_DIR VERILATOR"

test:
	$(VERILATOR) $(VFLAGS) -f src.f
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
